// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// integer register and data word width
`define XLEN 32
// 32 architectural registers
`define REG_ADDR_W 5

//////////////////////////////////////////////////
// memories and reset
//////////////////////////////////////////////////

// instruction memory size in words
`define IMEM_DEPTH 256
// data memory size in words
`define DMEM_DEPTH 256

// first fetch address once reset is released
`define RESET_PC 32'h0000_0000

`endif

// ==== cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

  // one data word and one register index
  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_func_t;

  // execute operand source
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  // register writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_t;

endpackage

// ==== fetch_stage.sv ====
`include "cpu_defines.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  stall,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  logic  imem_we,
  input  word_t imem_addr,
  input  word_t imem_data,
  output word_t id_pc,
  output word_t id_instr
);

  localparam int IMEM_AW = $clog2(`IMEM_DEPTH);
  // addi x0, x0, 0
  localparam word_t NOP = 32'h0000_0013;

  word_t pc;
  word_t pc_plus_4;
  word_t if_instr;
  word_t imem [`IMEM_DEPTH];

  // program load port only active while the core sits in reset
  always_ff @(posedge clk) begin
    if (!rstn && imem_we) begin
      imem[imem_addr[IMEM_AW-1:0]] <= imem_data;
    end
  end

  assign pc_plus_4 = pc + word_t'(4);
  // byte pc to word index
  assign if_instr  = imem[pc[IMEM_AW+1:2]];

  //////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////

  // redirect beats stall
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc_plus_4;
    end
  end

  // if/id register
  // squashed to a nop on reset or redirect
  always_ff @(posedge clk) begin
    if (!rstn || redirect) begin
      id_pc    <= '0;
      id_instr <= NOP;
    end else if (!stall) begin
      id_pc    <= pc;
      id_instr <= if_instr;
    end
  end

endmodule

// ==== decode_stage.sv ====
`include "cpu_defines.svh"

module decode_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       stall,
  input  logic       redirect,
  input  word_t      id_pc,
  input  word_t      id_instr,
  input  logic       wb_we,
  input  reg_addr_t  wb_rd,
  input  word_t      wb_data,
  output word_t      ex_pc,
  output word_t      ex_rs1_val,
  output word_t      ex_rs2_val,
  output word_t      ex_imm,
  output reg_addr_t  ex_rs1,
  output reg_addr_t  ex_rs2,
  output reg_addr_t  ex_rd,
  output alu_func_t  ex_alu_func,
  output logic       ex_alu_src,
  output logic       ex_branch,
  output logic       ex_jump,
  output logic       ex_mem_read,
  output logic       ex_mem_write,
  output logic       ex_reg_write,
  output logic [2:0] ex_funct3,
  output wb_sel_t    ex_wb_sel,
  output reg_addr_t  id_rs1,
  output reg_addr_t  id_rs2
);

  localparam int NUM_REGS = 2 ** `REG_ADDR_W;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  reg_addr_t  rd;
  word_t      imm_i, imm_s, imm_b, imm_j, imm;
  alu_func_t  arith_func, alu_func;
  logic       alu_src, branch, jump, mem_read, mem_write, reg_write;
  logic       use_rs1, use_rs2;
  wb_sel_t    wb_sel;
  word_t      rs1_val, rs2_val;
  word_t      regs [NUM_REGS];

  assign opcode    = opcode_t'(id_instr[6:0]);
  assign funct3    = id_instr[14:12];
  assign funct7_b5 = id_instr[30];
  assign rd        = id_instr[11:7];
  // unused source fields read as x0 so no false stall or forward
  assign id_rs1    = use_rs1 ? id_instr[19:15] : '0;
  assign id_rs2    = use_rs2 ? id_instr[24:20] : '0;

  //////////////////////////////////////////////////
  // main control
  //////////////////////////////////////////////////

  // unknown opcodes decode as a nop
  assign reg_write = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JAL};
  assign use_rs1   = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
  assign use_rs2   = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};
  assign alu_src   = opcode inside {OPC_OP_IMM, OPC_LOAD, OPC_STORE};
  assign branch    = (opcode == OPC_BRANCH);
  assign jump      = (opcode == OPC_JAL);
  assign mem_read  = (opcode == OPC_LOAD);
  assign mem_write = (opcode == OPC_STORE);
  assign wb_sel    = mem_read ? WB_LOAD : (jump ? WB_PC4 : WB_ALU);

  // alu op from funct3
  // funct7 bit 30 picks sub only for reg-reg
  always_comb begin
    case (funct3)
      3'b000:  arith_func = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_func = ALU_SLL;
      3'b010:  arith_func = ALU_SLT;
      3'b011:  arith_func = ALU_SLTU;
      3'b100:  arith_func = ALU_XOR;
      3'b101:  arith_func = funct7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  arith_func = ALU_OR;
      default: arith_func = ALU_AND;
    endcase
  end

  // address calc for load and store uses add
  assign alu_func = (opcode inside {OPC_OP, OPC_OP_IMM}) ? arith_func : ALU_ADD;

  // immediate formats
  assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
  assign imm_s = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
  assign imm_b = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
  assign imm_j = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20], id_instr[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OPC_STORE:  imm = imm_s;
      OPC_BRANCH: imm = imm_b;
      OPC_JAL:    imm = imm_j;
      default:    imm = imm_i;
    endcase
  end

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////

  // x0 never written since wb_we excludes rd zero
  always_ff @(posedge clk) begin
    if (wb_we) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // write-first bypass
  assign rs1_val = (id_rs1 == '0) ? '0 :
                   ((wb_we && wb_rd == id_rs1) ? wb_data : regs[id_rs1]);
  assign rs2_val = (id_rs2 == '0) ? '0 :
                   ((wb_we && wb_rd == id_rs2) ? wb_data : regs[id_rs2]);

  // id/ex control
  // bubble on stall or squash
  always_ff @(posedge clk) begin
    if (!rstn || stall || redirect) begin
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_branch    <= 1'b0;
      ex_jump      <= 1'b0;
      ex_rd        <= '0;
    end else begin
      ex_reg_write <= reg_write;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
      ex_branch    <= branch;
      ex_jump      <= jump;
      ex_rd        <= rd;
    end
  end

  // id/ex payload
  always_ff @(posedge clk) begin
    ex_pc       <= id_pc;
    ex_rs1_val  <= rs1_val;
    ex_rs2_val  <= rs2_val;
    ex_imm      <= imm;
    ex_rs1      <= id_rs1;
    ex_rs2      <= id_rs2;
    ex_alu_func <= alu_func;
    ex_alu_src  <= alu_src;
    ex_funct3   <= funct3;
    ex_wb_sel   <= wb_sel;
  end

endmodule

// ==== hazard_unit.sv ====
module hazard_unit import cpu_pkg::*; (
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  reg_addr_t ex_rs1,
  input  reg_addr_t ex_rs2,
  input  reg_addr_t ex_rd,
  input  reg_addr_t mem_rd,
  input  logic      ex_mem_read,
  input  logic      mem_reg_write,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  output logic      stall,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b
);

  // youngest producer wins
  // memory stage before writeback
  function automatic fwd_sel_t fwd_pick(input reg_addr_t src,
                                        input logic      m_we,
                                        input reg_addr_t m_rd,
                                        input logic      w_we,
                                        input reg_addr_t w_rd);
    if (m_we && m_rd != '0 && m_rd == src) begin
      return FWD_MEM;
    end
    if (w_we && w_rd != '0 && w_rd == src) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  //////////////////////////////////////////////////
  // load-use stall
  //////////////////////////////////////////////////

  // load in execute feeding the instruction in decode
  // one bubble then writeback forwarding covers it
  assign stall = ex_mem_read && (ex_rd != '0) &&
                 ((ex_rd == id_rs1) || (ex_rd == id_rs2));

  //////////////////////////////////////////////////
  // forward selects
  //////////////////////////////////////////////////

  assign fwd_a = fwd_pick(ex_rs1, mem_reg_write, mem_rd, wb_we, wb_rd);
  assign fwd_b = fwd_pick(ex_rs2, mem_reg_write, mem_rd, wb_we, wb_rd);

endmodule

// ==== execute_stage.sv ====
`include "cpu_defines.svh"

module execute_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  word_t      ex_pc,
  input  word_t      ex_rs1_val,
  input  word_t      ex_rs2_val,
  input  word_t      ex_imm,
  input  reg_addr_t  ex_rs2,
  input  reg_addr_t  ex_rd,
  input  alu_func_t  ex_alu_func,
  input  logic       ex_alu_src,
  input  logic       ex_branch,
  input  logic       ex_jump,
  input  logic       ex_mem_read,
  input  logic       ex_mem_write,
  input  logic       ex_reg_write,
  input  logic [2:0] ex_funct3,
  input  wb_sel_t    ex_wb_sel,
  input  fwd_sel_t   fwd_a,
  input  fwd_sel_t   fwd_b,
  input  word_t      wb_data,
  output logic       redirect,
  output word_t      redirect_pc,
  output word_t      mem_result,
  output word_t      mem_store_data,
  output reg_addr_t  mem_rd,
  output reg_addr_t  mem_rs2,
  output logic       mem_mem_read,
  output logic       mem_mem_write,
  output logic       mem_reg_write,
  output wb_sel_t    mem_wb_sel,
  output word_t      mem_pc_plus_4
);

  localparam int SHAMT_W = $clog2(`XLEN);

  word_t              rs1_fwd, rs2_fwd, op_b, alu_result;
  logic [SHAMT_W-1:0] shamt;
  logic               cond;

  function automatic word_t fwd_mux(input fwd_sel_t sel,
                                    input word_t    rf_val,
                                    input word_t    mem_val,
                                    input word_t    wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  // mem_result is the ex/mem alu value of the previous instruction
  assign rs1_fwd = fwd_mux(fwd_a, ex_rs1_val, mem_result, wb_data);
  // also the store data
  assign rs2_fwd = fwd_mux(fwd_b, ex_rs2_val, mem_result, wb_data);
  assign op_b    = ex_alu_src ? ex_imm : rs2_fwd;
  assign shamt   = op_b[SHAMT_W-1:0];

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  always_comb begin
    case (ex_alu_func)
      ALU_SUB:  alu_result = rs1_fwd - op_b;
      ALU_AND:  alu_result = rs1_fwd & op_b;
      ALU_OR:   alu_result = rs1_fwd | op_b;
      ALU_XOR:  alu_result = rs1_fwd ^ op_b;
      ALU_SLT:  alu_result = word_t'($signed(rs1_fwd) < $signed(op_b));
      ALU_SLTU: alu_result = word_t'(rs1_fwd < op_b);
      ALU_SLL:  alu_result = rs1_fwd << shamt;
      ALU_SRL:  alu_result = rs1_fwd >> shamt;
      ALU_SRA:  alu_result = word_t'($signed(rs1_fwd) >>> shamt);
      default:  alu_result = rs1_fwd + op_b;
    endcase
  end

  // branch condition on the forwarded register values
  always_comb begin
    case (ex_funct3)
      3'b000:  cond = (rs1_fwd == rs2_fwd);
      3'b001:  cond = (rs1_fwd != rs2_fwd);
      3'b100:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
      3'b101:  cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
      default: cond = 1'b0;
    endcase
  end

  // jal and taken branch share the pc-relative target
  assign redirect    = ex_jump || (ex_branch && cond);
  assign redirect_pc = ex_pc + ex_imm;

  //////////////////////////////////////////////////
  // ex/mem register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_reg_write <= 1'b0;
    end else begin
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    mem_result     <= alu_result;
    mem_store_data <= rs2_fwd;
    mem_rd         <= ex_rd;
    mem_rs2        <= ex_rs2;
    mem_wb_sel     <= ex_wb_sel;
    mem_pc_plus_4  <= ex_pc + word_t'(4);
  end

endmodule

// ==== memory_stage.sv ====
`include "cpu_defines.svh"

module memory_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  word_t     mem_result,
  input  word_t     mem_store_data,
  input  word_t     mem_pc_plus_4,
  input  reg_addr_t mem_rd,
  input  reg_addr_t mem_rs2,
  input  logic      mem_mem_read,
  input  logic      mem_mem_write,
  input  logic      mem_reg_write,
  input  wb_sel_t   mem_wb_sel,
  output logic      wb_we,
  output reg_addr_t wb_rd,
  output word_t     wb_data
);

  localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

  word_t              dmem [`DMEM_DEPTH];
  logic [DMEM_AW-1:0] dmem_idx;
  word_t              store_data, load_data;
  logic               wb_reg_write;
  word_t              wb_result, wb_load_data, wb_pc_plus_4;
  wb_sel_t            wb_sel;

  // word address from the alu result
  assign dmem_idx   = mem_result[DMEM_AW+1:2];
  // store of a value retiring this cycle
  assign store_data = (wb_we && wb_rd == mem_rs2) ? wb_data : mem_store_data;
  assign load_data  = mem_mem_read ? dmem[dmem_idx] : '0;

  always_ff @(posedge clk) begin
    if (mem_mem_write) begin
      dmem[dmem_idx] <= store_data;
    end
  end

  //////////////////////////////////////////////////
  // mem/wb register and writeback select
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb_reg_write <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd        <= mem_rd;
    wb_result    <= mem_result;
    wb_load_data <= load_data;
    wb_pc_plus_4 <= mem_pc_plus_4;
    wb_sel       <= mem_wb_sel;
  end

  // x0 writes dropped here
  assign wb_we = wb_reg_write && (wb_rd != '0);

  always_comb begin
    case (wb_sel)
      WB_LOAD: wb_data = wb_load_data;
      WB_PC4:  wb_data = wb_pc_plus_4;
      default: wb_data = wb_result;
    endcase
  end

endmodule

// ==== rv32_core.sv ====
module rv32_core import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      imem_we,
  input  word_t     imem_addr,
  input  word_t     imem_data,
  output logic      trace_we,
  output reg_addr_t trace_rd,
  output word_t     trace_data
);

  // if/id and decode sources
  word_t      id_pc, id_instr;
  reg_addr_t  id_rs1, id_rs2;

  // id/ex
  word_t      ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
  reg_addr_t  ex_rs1, ex_rs2, ex_rd;
  alu_func_t  ex_alu_func;
  logic       ex_alu_src, ex_branch, ex_jump;
  logic       ex_mem_read, ex_mem_write, ex_reg_write;
  logic [2:0] ex_funct3;
  wb_sel_t    ex_wb_sel;

  // redirect from execute
  logic       redirect;
  word_t      redirect_pc;

  // ex/mem
  word_t      mem_result, mem_store_data, mem_pc_plus_4;
  reg_addr_t  mem_rd, mem_rs2;
  logic       mem_mem_read, mem_mem_write, mem_reg_write;
  wb_sel_t    mem_wb_sel;

  // writeback
  logic       wb_we;
  reg_addr_t  wb_rd;
  word_t      wb_data;

  // hazard controls
  logic       stall;
  fwd_sel_t   fwd_a, fwd_b;

  //////////////////////////////////////////////////
  // pipeline stages
  //////////////////////////////////////////////////

  fetch_stage   u_fetch   (.*);
  decode_stage  u_decode  (.*);
  hazard_unit   u_hazard  (.*);
  execute_stage u_execute (.*);
  memory_stage  u_memory  (.*);

  // retiring register writes
  assign trace_we   = wb_we;
  assign trace_rd   = wb_rd;
  assign trace_data = wb_data;

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rstn
);

  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release just after the last reset edge
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rstn = 1'b1;
  end

endmodule

// ==== tb_rv32_core.sv ====
module tb_rv32_core import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int MAX_RECORDS  = 64;
  // quiet cycles watched after the last expected write
  localparam int DRAIN_CYCLES = 8;

  logic      clk;
  logic      rstn;
  logic      imem_we;
  word_t     imem_addr;
  word_t     imem_data;
  logic      trace_we;
  reg_addr_t trace_rd;
  word_t     trace_data;

  // each record is kind, first field, second field
  word_t     records [3*MAX_RECORDS];
  word_t     prog_addr [$];
  word_t     prog_word [$];
  reg_addr_t exp_rd [$];
  word_t     exp_data [$];
  int        cycle_count = 0;
  int        cycle_limit;

  tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  rv32_core u_rv32_core (.*);

  // timeout counter runs through reset too
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_rd(input reg_addr_t got, input reg_addr_t want, input int idx);
    if (got !== want) begin
      stop_on_error($sformatf("ERROR at time %0t: trace entry %0d wrote x%0d, expected x%0d",
                              $time, idx, got, want));
    end
  endtask

  task automatic check_word(input word_t got, input word_t want, input int idx);
    if (got !== want) begin
      stop_on_error($sformatf("ERROR at time %0t: trace entry %0d data %08h, expected %08h",
                              $time, idx, got, want));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus file
  //////////////////////////////////////////////////

  // split records into program words and expected writes
  task automatic read_input();
    int    i;
    bit    done;
    word_t kind;
    $readmemh("core_input.txt", records);
    i    = 0;
    done = 1'b0;
    while (!done) begin
      if (i == MAX_RECORDS) begin
        stop_on_error("core_input.txt has no end record");
      end
      kind = records[3*i];
      case (kind)
        32'h0: begin
          prog_addr.push_back(records[3*i+1]);
          prog_word.push_back(records[3*i+2]);
        end
        32'h1: begin
          exp_rd.push_back(records[3*i+1][4:0]);
          exp_data.push_back(records[3*i+2]);
        end
        32'h2: done = 1'b1;
        default: stop_on_error($sformatf("core_input.txt record %0d has unknown kind %0h",
                                         i, kind));
      endcase
      i++;
    end
  endtask

  // one word per reset edge
  // first word already waiting before edge one
  task automatic load_program();
    int i;
    if (prog_addr.size() == 0 || prog_addr.size() > RESET_CYCLES) begin
      stop_on_error("program does not fit into the reset window");
    end
    imem_we   = 1'b1;
    imem_addr = prog_addr[0];
    imem_data = prog_word[0];
    for (i = 1; i < prog_addr.size(); i++) begin
      @(posedge clk);
      #1;
      imem_addr = prog_addr[i];
      imem_data = prog_word[i];
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // trace checking
  //////////////////////////////////////////////////

  initial begin
    int        idx;
    int        quiet;
    reg_addr_t want_rd;
    word_t     want_data;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    read_input();
    cycle_limit = RESET_CYCLES + 8 * exp_rd.size() + 64;
    load_program();
    idx   = 0;
    quiet = 0;
    // wb outputs settled by the falling edge
    while ((exp_rd.size() > 0 || quiet < DRAIN_CYCLES) && cycle_count < cycle_limit) begin
      @(negedge clk);
      if (trace_we && exp_rd.size() == 0) begin
        stop_on_error($sformatf("ERROR at time %0t: unexpected writeback to x%0d",
                                $time, trace_rd));
      end else if (trace_we) begin
        want_rd   = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        check_rd(trace_rd, want_rd, idx);
        check_word(trace_data, want_data, idx);
        idx++;
      end else if (exp_rd.size() == 0) begin
        quiet++;
      end
    end
    if (exp_rd.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_on_error("timeout: writeback trace incomplete");
    end
  end

endmodule

// ==== core_input.txt ====
// kind 0: imem word index, instruction   kind 1: rd, expected writeback data
// kind 2 ends the records, all fields hex
0 00 FFB00093  // addi x1, x0, -5
0 01 00300113  // addi x2, x0, 3
0 02 401101B3  // sub  x3, x2, x1   mem and wb forwarding
0 03 4020D233  // sra  x4, x1, x2   regfile bypass
0 04 00302223  // sw   x3, 4(x0)
0 05 00402283  // lw   x5, 4(x0)
0 06 00502423  // sw   x5, 8(x0)    store of a loaded value
0 07 00802303  // lw   x6, 8(x0)
0 08 005303B3  // add  x7, x6, x5   load-use bubble
0 09 00338463  // beq  x7, x3, +8   not taken
0 0A 0020D463  // bge  x1, x2, +8   not taken
0 0B 00339463  // bne  x7, x3, +8   taken
0 0C 00100413  // addi x8, x0, 1    squashed
0 0D 008004EF  // jal  x9, +8
0 0E 00100513  // addi x10, x0, 1   squashed
0 0F 0000006F  // jal  x0, 0        parking loop
// writeback trace in program order
1 01 FFFFFFFB
1 02 00000003
1 03 00000008
1 04 FFFFFFFF
1 05 00000008
1 06 00000008
1 07 00000010
1 09 00000038
2 00 00000000

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
rv32_core.sv
tb_clock.sv
tb_rv32_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv32 core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
  --top-module tb_rv32_core -o sim_rv32
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_rv32 > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
